//--- hdl/lsu_settings.svh
// load/store unit settings
// data, address and memory dimensions shared by the RTL and the bench
`ifndef LSU_SETTINGS_SVH
`define LSU_SETTINGS_SVH

// requester side data width
`define LSU_DATA_W 32

// one memory word is a halfword
`define LSU_MEM_W 16

// byte address, 256 bytes
`define LSU_ADDR_W 8

// halfwords in the local memory
`define LSU_MEM_DEPTH 128

`endif

//--- hdl/lsu_pkg.sv
// load/store unit package
// access size and operation codes seen on the request port

package lsu_pkg;

  // access size of a request
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'd0,
    SIZE_HALF = 2'd1,
    SIZE_WORD = 2'd2,
    SIZE_RSVD = 2'd3  // refused with err
  } size_t;

  // direction of a request
  typedef enum logic {
    OP_LOAD  = 1'b0,
    OP_STORE = 1'b1
  } op_t;

endpackage

//--- hdl/halfword_ram.sv
// halfword data memory
// 16 bit wide single port RAM, read data registered one cycle after en
`timescale 1ns/100ps
`include "lsu_settings.svh"

module halfword_ram (
  input  logic                   clk,
  input  logic                   en,
  input  logic                   we,
  input  logic [`LSU_ADDR_W-2:0] addr,
  input  logic [`LSU_MEM_W-1:0]  wdata,
  output logic [`LSU_MEM_W-1:0]  rdata
);

  // byte 2n in bits 7:0, byte 2n+1 in bits 15:8
  logic [`LSU_MEM_W-1:0] mem [`LSU_MEM_DEPTH];

  always_ff @(posedge clk) begin
    if (en) begin
      if (we) begin
        mem[addr] <= wdata;
      end else begin
        rdata <= mem[addr]; // holds until the next read
      end
    end
  end

endmodule

//--- hdl/lsu_decode.sv
// lsu request decode
// takes a request on the req/ack handshake, latches it, checks alignment
// and either starts the memory sequence or refuses with err
`timescale 1ns/100ps
`include "lsu_settings.svh"

module lsu_decode import lsu_pkg::*; (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     req,
  input  op_t                      op,
  input  size_t                    size,
  input  logic                     is_signed,
  input  logic [`LSU_ADDR_W-1:0]   addr,
  input  logic [`LSU_DATA_W-1:0]   wdata,
  input  logic                     done,
  output logic                     ack,
  output logic                     err,
  output logic                     start,
  output op_t                      op_q,
  output size_t                    size_q,
  output logic                     signed_q,
  output logic [`LSU_ADDR_W-2:0]   hw_addr,
  output logic                     byte_lane,
  output logic [`LSU_DATA_W-1:0]   wdata_q
);

  localparam logic [1:0] S_IDLE  = 2'd0;
  localparam logic [1:0] S_CHECK = 2'd1;
  localparam logic [1:0] S_BUSY  = 2'd2;
  localparam logic [1:0] S_ACK   = 2'd3;

  logic [1:0]             state;
  logic [`LSU_ADDR_W-1:0] addr_q;
  logic                   misaligned;

  assign hw_addr   = addr_q[`LSU_ADDR_W-1:1]; // halfword index
  assign byte_lane = addr_q[0];

  // refused sizes and addresses that straddle a boundary
  assign misaligned = (size_q == SIZE_RSVD) ||
                      (size_q == SIZE_HALF && addr_q[0]) ||
                      (size_q == SIZE_WORD && addr_q[1:0] != 2'b00);

  always_ff @(posedge clk) begin
    if (!reset) begin
      state <= S_IDLE;
      ack   <= 1'b0;
      err   <= 1'b0;
      start <= 1'b0;
    end else begin
      start <= 1'b0; // single cycle pulse
      case (state)
        S_IDLE: begin
          if (req) state <= S_CHECK;
        end
        S_CHECK: begin
          if (misaligned) begin
            ack   <= 1'b1; // refuse, no memory access
            err   <= 1'b1;
            state <= S_ACK;
          end else begin
            start <= 1'b1;
            state <= S_BUSY;
          end
        end
        S_BUSY: begin
          if (done) begin
            ack   <= 1'b1;
            state <= S_ACK;
          end
        end
        default: begin
          if (!req) begin // requester let go
            ack   <= 1'b0;
            err   <= 1'b0;
            state <= S_IDLE;
          end
        end
      endcase
    end
  end

  // request fields, held for the whole access
  always_ff @(posedge clk) begin
    if (state == S_IDLE && req) begin
      op_q     <= op;
      size_q   <= size;
      signed_q <= is_signed;
      addr_q   <= addr;
      wdata_q  <= wdata;
    end
  end

endmodule

//--- hdl/memory_control_fsm.sv
// memory control state machine
// orders the halfword reads and writes for each access size and operation,
// and drives the capture and store data selects of the result block
`timescale 1ns/100ps

module memory_control_fsm import lsu_pkg::*; (
  input  logic  clk,
  input  logic  reset,
  input  logic  start,
  input  op_t   op_q,
  input  size_t size_q,
  output logic  done,
  output logic  mem_en,
  output logic  mem_we,
  output logic  addr_plus_one,
  output logic  cap_low,
  output logic  cap_high,
  output logic  merge_sel,
  output logic  store_upper
);

  localparam logic [3:0] IDLE           = 4'd0;
  localparam logic [3:0] LOAD_HW        = 4'd1;
  localparam logic [3:0] LOAD_BYTE      = 4'd2;
  localparam logic [3:0] LOAD_WORD_A    = 4'd3;
  localparam logic [3:0] LOAD_WORD_B    = 4'd4;
  localparam logic [3:0] WAIT_LOW       = 4'd5;
  localparam logic [3:0] WAIT_HIGH      = 4'd6;
  localparam logic [3:0] STORE_HW       = 4'd7;
  localparam logic [3:0] STORE_BYTE_RD  = 4'd8;
  localparam logic [3:0] STORE_BYTE_CAP = 4'd9;
  localparam logic [3:0] STORE_BYTE_WR  = 4'd10;
  localparam logic [3:0] STORE_WORD_A   = 4'd11;
  localparam logic [3:0] STORE_WORD_B   = 4'd12;

  logic [3:0] state;
  logic [3:0] nextstate;
  logic [7:0] ctrl; // done en we plus1 cap_low cap_high merge upper

  always_ff @(posedge clk) begin
    if (!reset) begin
      state <= IDLE;
    end else begin
      state <= nextstate;
    end
  end

  // state transitions
  always_comb begin
    case (state)
      IDLE: begin
        nextstate = IDLE;
        if (start) begin
          if (op_q == OP_LOAD) begin
            case (size_q)
              SIZE_BYTE: nextstate = LOAD_BYTE;
              SIZE_HALF: nextstate = LOAD_HW;
              SIZE_WORD: nextstate = LOAD_WORD_A;
              default:   nextstate = IDLE; // never started by decode
            endcase
          end else begin
            case (size_q)
              SIZE_BYTE: nextstate = STORE_BYTE_RD;
              SIZE_HALF: nextstate = STORE_HW;
              SIZE_WORD: nextstate = STORE_WORD_A;
              default:   nextstate = IDLE;
            endcase
          end
        end
      end
      LOAD_HW:        nextstate = WAIT_LOW;
      LOAD_BYTE:      nextstate = WAIT_LOW;
      LOAD_WORD_A:    nextstate = LOAD_WORD_B;
      LOAD_WORD_B:    nextstate = WAIT_HIGH; // low half lands here
      STORE_BYTE_RD:  nextstate = STORE_BYTE_CAP;
      STORE_BYTE_CAP: nextstate = STORE_BYTE_WR;
      STORE_WORD_A:   nextstate = STORE_WORD_B;
      default:        nextstate = IDLE; // last state of every access
    endcase
  end

  // output table, one row per state
  always_comb begin
    case (state)
      LOAD_HW:        ctrl = 8'b0100_0000;
      LOAD_BYTE:      ctrl = 8'b0100_0000;
      LOAD_WORD_A:    ctrl = 8'b0100_0000; // read base
      LOAD_WORD_B:    ctrl = 8'b0101_1000; // read base+1, take low half
      WAIT_LOW:       ctrl = 8'b1000_1000;
      WAIT_HIGH:      ctrl = 8'b1000_0100;
      STORE_HW:       ctrl = 8'b1110_0000;
      STORE_BYTE_RD:  ctrl = 8'b0100_0000; // fetch old halfword
      STORE_BYTE_CAP: ctrl = 8'b0000_1000;
      STORE_BYTE_WR:  ctrl = 8'b1110_0010; // write merged halfword
      STORE_WORD_A:   ctrl = 8'b0110_0000; // low half at base
      STORE_WORD_B:   ctrl = 8'b1111_0001; // high half at base+1
      default:        ctrl = 8'b0000_0000;
    endcase
  end

  assign done          = ctrl[7];
  assign mem_en        = ctrl[6];
  assign mem_we        = ctrl[5];
  assign addr_plus_one = ctrl[4];
  assign cap_low       = ctrl[3];
  assign cap_high      = ctrl[2];
  assign merge_sel     = ctrl[1];
  assign store_upper   = ctrl[0];

endmodule

//--- hdl/lsu_result.sv
// lsu result shaping
// captures the halfwords read from memory, forms the extended load result
// and the halfword written on a store
`timescale 1ns/100ps
`include "lsu_settings.svh"

module lsu_result import lsu_pkg::*; (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   cap_low,
  input  logic                   cap_high,
  input  logic                   merge_sel,
  input  logic                   store_upper,
  input  size_t                  size_q,
  input  logic                   signed_q,
  input  logic                   byte_lane,
  input  logic [`LSU_MEM_W-1:0]  mem_rdata,
  input  logic [`LSU_DATA_W-1:0] wdata_q,
  output logic [`LSU_MEM_W-1:0]  mem_wdata,
  output logic [`LSU_DATA_W-1:0] rdata
);

  logic [`LSU_MEM_W-1:0] low_q;
  logic [`LSU_MEM_W-1:0] high_q;
  logic [7:0]            lane_byte;
  logic [`LSU_MEM_W-1:0] merged;
  logic [`LSU_MEM_W-1:0] direct;

  always_ff @(posedge clk) begin
    if (!reset) begin
      low_q  <= '0;
      high_q <= '0;
    end else begin
      if (cap_low)  low_q  <= mem_rdata; // also the old halfword of a byte store
      if (cap_high) high_q <= mem_rdata;
    end
  end

  // little-endian, odd address is the upper byte
  assign lane_byte = byte_lane ? low_q[15:8] : low_q[7:0];

  always_comb begin
    case (size_q)
      SIZE_BYTE: rdata = {{24{signed_q & lane_byte[7]}}, lane_byte};
      SIZE_HALF: rdata = {{16{signed_q & low_q[15]}}, low_q};
      SIZE_WORD: rdata = {high_q, low_q};
      default:   rdata = '0;
    endcase
  end

  // replace only the addressed byte
  assign merged = byte_lane ? {wdata_q[7:0], low_q[7:0]}
                            : {low_q[15:8], wdata_q[7:0]};

  assign direct = store_upper ? wdata_q[31:16] : wdata_q[15:0];

  assign mem_wdata = merge_sel ? merged : direct;

endmodule

//--- hdl/lsu_top.sv
// load/store unit top
// request decode, memory control, result shaping and the halfword memory
`timescale 1ns/100ps
`include "lsu_settings.svh"

module lsu_top import lsu_pkg::*; (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   req,
  input  op_t                    op,
  input  size_t                  size,
  input  logic                   is_signed,
  input  logic [`LSU_ADDR_W-1:0] addr,
  input  logic [`LSU_DATA_W-1:0] wdata,
  output logic                   ack,
  output logic                   err,
  output logic [`LSU_DATA_W-1:0] rdata
);

  logic                   start;
  logic                   done;
  op_t                    op_q;
  size_t                  size_q;
  logic                   signed_q;
  logic [`LSU_ADDR_W-2:0] hw_addr;
  logic                   byte_lane;
  logic [`LSU_DATA_W-1:0] wdata_q;
  logic                   mem_en;
  logic                   mem_we;
  logic                   addr_plus_one;
  logic                   cap_low;
  logic                   cap_high;
  logic                   merge_sel;
  logic                   store_upper;
  logic [`LSU_ADDR_W-2:0] mem_addr;
  logic [`LSU_MEM_W-1:0]  mem_rdata;
  logic [`LSU_MEM_W-1:0]  mem_wdata;

  // second halfword of a word access
  assign mem_addr = hw_addr + {{(`LSU_ADDR_W-2){1'b0}}, addr_plus_one};

  lsu_decode i_decode (
    .clk(clk), .reset(reset), .req(req), .op(op), .size(size),
    .is_signed(is_signed), .addr(addr), .wdata(wdata), .done(done),
    .ack(ack), .err(err), .start(start), .op_q(op_q), .size_q(size_q),
    .signed_q(signed_q), .hw_addr(hw_addr), .byte_lane(byte_lane),
    .wdata_q(wdata_q)
  );

  memory_control_fsm i_ctrl (
    .clk(clk), .reset(reset), .start(start), .op_q(op_q), .size_q(size_q),
    .done(done), .mem_en(mem_en), .mem_we(mem_we),
    .addr_plus_one(addr_plus_one), .cap_low(cap_low), .cap_high(cap_high),
    .merge_sel(merge_sel), .store_upper(store_upper)
  );

  lsu_result i_result (
    .clk(clk), .reset(reset), .cap_low(cap_low), .cap_high(cap_high),
    .merge_sel(merge_sel), .store_upper(store_upper), .size_q(size_q),
    .signed_q(signed_q), .byte_lane(byte_lane), .mem_rdata(mem_rdata),
    .wdata_q(wdata_q), .mem_wdata(mem_wdata), .rdata(rdata)
  );

  halfword_ram i_ram (
    .clk(clk), .en(mem_en), .we(mem_we), .addr(mem_addr),
    .wdata(mem_wdata), .rdata(mem_rdata)
  );

endmodule

//--- bench/lsu_vectors.svh
// load/store unit request table
// one row per request, with the expected err and load result
`ifndef LSU_VECTORS_SVH
`define LSU_VECTORS_SVH

typedef struct packed {
  op_t                    op;
  size_t                  size;
  logic                   sgn;
  logic [`LSU_ADDR_W-1:0] addr;
  logic [`LSU_DATA_W-1:0] wdata;      // ignored when rnd is set
  logic                   rnd;        // wdata from $urandom
  logic                   exp_err;
  logic                   from_model; // expected load data from the byte model
  logic [`LSU_DATA_W-1:0] exp_rdata;
} vec_t;

localparam int NUM_ROWS = 29;

// columns: op, size, signed, addr, wdata, rnd, err, from_model, rdata
localparam vec_t VECTORS [NUM_ROWS] = '{
  '{OP_STORE, SIZE_WORD, 1'b0, 8'h10, 32'h8765_4321, 1'b0, 1'b0, 1'b0, 32'h0},
  '{OP_LOAD,  SIZE_WORD, 1'b0, 8'h10, 32'h0,         1'b0, 1'b0, 1'b0, 32'h8765_4321},
  '{OP_LOAD,  SIZE_HALF, 1'b0, 8'h10, 32'h0,         1'b0, 1'b0, 1'b0, 32'h0000_4321},
  '{OP_LOAD,  SIZE_HALF, 1'b1, 8'h12, 32'h0,         1'b0, 1'b0, 1'b0, 32'hffff_8765},
  '{OP_LOAD,  SIZE_HALF, 1'b0, 8'h12, 32'h0,         1'b0, 1'b0, 1'b0, 32'h0000_8765},
  '{OP_STORE, SIZE_HALF, 1'b0, 8'h20, 32'h1234_a5f0, 1'b0, 1'b0, 1'b0, 32'h0},
  '{OP_STORE, SIZE_BYTE, 1'b0, 8'h20, 32'hdead_be3c, 1'b0, 1'b0, 1'b0, 32'h0},
  '{OP_LOAD,  SIZE_HALF, 1'b0, 8'h20, 32'h0,         1'b0, 1'b0, 1'b0, 32'h0000_a53c},
  '{OP_STORE, SIZE_BYTE, 1'b0, 8'h21, 32'h5555_55c7, 1'b0, 1'b0, 1'b0, 32'h0},
  '{OP_LOAD,  SIZE_HALF, 1'b0, 8'h20, 32'h0,         1'b0, 1'b0, 1'b0, 32'h0000_c73c},
  '{OP_LOAD,  SIZE_BYTE, 1'b1, 8'h20, 32'h0,         1'b0, 1'b0, 1'b0, 32'h0000_003c},
  '{OP_LOAD,  SIZE_BYTE, 1'b0, 8'h21, 32'h0,         1'b0, 1'b0, 1'b0, 32'h0000_00c7},
  '{OP_LOAD,  SIZE_BYTE, 1'b1, 8'h21, 32'h0,         1'b0, 1'b0, 1'b0, 32'hffff_ffc7},
  '{OP_LOAD,  SIZE_BYTE, 1'b0, 8'h20, 32'h0,         1'b0, 1'b0, 1'b0, 32'h0000_003c},
  // refused requests, memory must stay as it is
  '{OP_STORE, SIZE_HALF, 1'b0, 8'h11, 32'hffff_ffff, 1'b0, 1'b1, 1'b0, 32'h0},
  '{OP_STORE, SIZE_WORD, 1'b0, 8'h12, 32'hffff_ffff, 1'b0, 1'b1, 1'b0, 32'h0},
  '{OP_LOAD,  SIZE_WORD, 1'b0, 8'h11, 32'h0,         1'b0, 1'b1, 1'b0, 32'h0},
  '{OP_LOAD,  SIZE_HALF, 1'b0, 8'h13, 32'h0,         1'b0, 1'b1, 1'b0, 32'h0},
  '{OP_STORE, SIZE_RSVD, 1'b0, 8'h10, 32'hffff_ffff, 1'b0, 1'b1, 1'b0, 32'h0},
  '{OP_LOAD,  SIZE_WORD, 1'b0, 8'h10, 32'h0,         1'b0, 1'b0, 1'b0, 32'h8765_4321},
  // random data, checked against the byte model
  '{OP_STORE, SIZE_WORD, 1'b0, 8'h40, 32'h0,         1'b1, 1'b0, 1'b0, 32'h0},
  '{OP_LOAD,  SIZE_WORD, 1'b0, 8'h40, 32'h0,         1'b0, 1'b0, 1'b1, 32'h0},
  '{OP_STORE, SIZE_BYTE, 1'b0, 8'h41, 32'h0,         1'b1, 1'b0, 1'b0, 32'h0},
  '{OP_LOAD,  SIZE_WORD, 1'b0, 8'h40, 32'h0,         1'b0, 1'b0, 1'b1, 32'h0},
  '{OP_LOAD,  SIZE_BYTE, 1'b1, 8'h43, 32'h0,         1'b0, 1'b0, 1'b1, 32'h0},
  '{OP_LOAD,  SIZE_BYTE, 1'b0, 8'h41, 32'h0,         1'b0, 1'b0, 1'b1, 32'h0},
  '{OP_STORE, SIZE_HALF, 1'b0, 8'h42, 32'h0,         1'b1, 1'b0, 1'b0, 32'h0},
  '{OP_LOAD,  SIZE_HALF, 1'b1, 8'h42, 32'h0,         1'b0, 1'b0, 1'b1, 32'h0},
  '{OP_LOAD,  SIZE_WORD, 1'b0, 8'h40, 32'h0,         1'b0, 1'b0, 1'b1, 32'h0}
};

`endif

//--- bench/lsu_tb.sv
// load/store unit testbench
// runs the request table over the four-phase handshake and checks err,
// load data, cycles to ack and the hold of ack while req stays high
`timescale 1ns/100ps
`include "lsu_settings.svh"

module lsu_tb import lsu_pkg::*; ();

  `include "lsu_vectors.svh"

  localparam int RESET_CYCLES = 8;
  localparam int HOLD_CYCLES  = 2;
  localparam int CYCLE_LIMIT  = 10 * NUM_ROWS + RESET_CYCLES + 50;

  logic                   clk;
  logic                   reset;
  logic                   req;
  op_t                    op;
  size_t                  size;
  logic                   is_signed;
  logic [`LSU_ADDR_W-1:0] addr;
  logic [`LSU_DATA_W-1:0] wdata;
  logic                   ack;
  logic                   err;
  logic [`LSU_DATA_W-1:0] rdata;

  logic [7:0]  model_mem [1 << `LSU_ADDR_W]; // byte view of the memory
  int          cycles = 0;

  lsu_top i_dut (
    .clk(clk), .reset(reset), .req(req), .op(op), .size(size),
    .is_signed(is_signed), .addr(addr), .wdata(wdata),
    .ack(ack), .err(err), .rdata(rdata)
  );

  always #10 clk = ~clk;

  // run limit
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: no verdict after %0d clock cycles", CYCLE_LIMIT);
      $display(">>> FAIL");
      $fatal(1, "run stopped by the cycle limit");
    end
  end

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("ERR at time %0t: %s, got %h, expected %h", $time, what, actual, expected);
      $display(">>> FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  // edges from the first sample of req to ack high
  function automatic int ack_latency(op_t o, size_t s, logic refused);
    if (refused) return 1;
    if (o == OP_STORE) begin
      case (s)
        SIZE_BYTE: return 5; // read, capture, write
        SIZE_HALF: return 3;
        default:   return 4;
      endcase
    end
    if (s == SIZE_WORD) return 5;
    return 4;
  endfunction

  // little-endian read with sign or zero extension
  function automatic logic [31:0] model_load(logic [7:0] a, size_t s, logic sgn);
    logic [31:0] v;
    case (s)
      SIZE_BYTE: v = {{24{sgn & model_mem[a][7]}}, model_mem[a]};
      SIZE_HALF: v = {{16{sgn & model_mem[a + 8'd1][7]}}, model_mem[a + 8'd1], model_mem[a]};
      default:   v = {model_mem[a + 8'd3], model_mem[a + 8'd2], model_mem[a + 8'd1],
                      model_mem[a]};
    endcase
    return v;
  endfunction

  task automatic model_store(logic [7:0] a, size_t s, logic [31:0] d);
    model_mem[a] = d[7:0];
    if (s != SIZE_BYTE) model_mem[a + 8'd1] = d[15:8];
    if (s == SIZE_WORD) begin
      model_mem[a + 8'd2] = d[23:16];
      model_mem[a + 8'd3] = d[31:24];
    end
  endtask

  // one full handshake, entered and left just after a falling edge
  task automatic apply_row(input int idx, input vec_t v);
    logic [31:0] row_wdata;
    logic [31:0] exp_rdata;
    logic [31:0] held;
    int          n;
    row_wdata = v.rnd ? $urandom() : v.wdata;
    op        = v.op;
    size      = v.size;
    is_signed = v.sgn;
    addr      = v.addr;
    wdata     = row_wdata;
    req       = 1'b1;
    n         = 0;
    do begin
      @(negedge clk);
      n++;
    end while (ack !== 1'b1);
    check_value(32'(n - 1), 32'(ack_latency(v.op, v.size, v.exp_err)),
                $sformatf("row %0d cycles to ack", idx));
    check_value(32'(err), 32'(v.exp_err), $sformatf("row %0d err", idx));
    if (v.op == OP_STORE && !v.exp_err) model_store(v.addr, v.size, row_wdata);
    if (v.op == OP_LOAD && !v.exp_err) begin
      exp_rdata = v.from_model ? model_load(v.addr, v.size, v.sgn) : v.exp_rdata;
      check_value(rdata, exp_rdata, $sformatf("row %0d load data", idx));
    end
    // requester keeps req high, nothing may move
    held = rdata;
    repeat (HOLD_CYCLES) begin
      @(negedge clk);
      check_value(32'(ack), 32'd1, $sformatf("row %0d ack during hold", idx));
      check_value(rdata, held, $sformatf("row %0d rdata during hold", idx));
      check_value(32'(i_dut.mem_en), 32'd0, $sformatf("row %0d access during hold", idx));
    end
    req = 1'b0;
    @(negedge clk);
    check_value(32'(ack), 32'd0, $sformatf("row %0d ack after req dropped", idx));
  endtask

  initial begin
    void'($urandom(83699));
    clk       = 1'b0;
    reset     = 1'b0;
    req       = 1'b0;
    op        = OP_LOAD;
    size      = SIZE_BYTE;
    is_signed = 1'b0;
    addr      = '0;
    wdata     = '0;
    repeat (RESET_CYCLES) @(negedge clk);
    reset = 1'b1;
    @(negedge clk);
    for (int i = 0; i < NUM_ROWS; i++) begin
      apply_row(i, VECTORS[i]);
    end
    $display(">>> PASS");
    $finish;
  end

endmodule

//--- list.f
+incdir+hdl
+incdir+bench
hdl/lsu_pkg.sv
hdl/halfword_ram.sv
hdl/lsu_decode.sv
hdl/memory_control_fsm.sv
hdl/lsu_result.sv
hdl/lsu_top.sv
bench/lsu_tb.sv

//--- Makefile
# Verilator build and run of the load/store unit testbench

VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = lsu_tb
FILELIST  = list.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

# build, run, and pass only when the run prints the pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q '>>> PASS'

clean:
	rm -rf $(OBJ_DIR)
